// ==== design/exec_pkg.sv ====
// Shared opcodes, CSR layout and execute-stage payload types
// RV32I subset only; the CSR holds one adder circuit select of four encodings
`default_nettype none

package exec_pkg;

    // ----------------------------------------------------------------------
    // Datapath and CSR geometry
    // ----------------------------------------------------------------------
    localparam int XLEN       = 32;                   // Integer register width
    localparam int APX_LEN    = 8;                    // Low adder bits that may approximate
    localparam int AXI_ADDR_W = 4;                    // CSR byte address width

    localparam logic [AXI_ADDR_W-1:0] CSR_ADDR_APX = 4'h0;   // Approximation control word

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // ----------------------------------------------------------------------
    // RV32 encodings
    // ----------------------------------------------------------------------
    localparam logic [6:0] OP     = 7'b0110011;       // R-type ALU
    localparam logic [6:0] OP_IMM = 7'b0010011;       // I-type ALU
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] AUIPC  = 7'b0010111;

    localparam logic [6:0] F7_BASE = 7'b0000000;      // Normal form
    localparam logic [6:0] F7_ALT  = 7'b0100000;      // SUB and SRA form

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;          // SRL or SRA by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // ----------------------------------------------------------------------
    // Approximation CSR, seen as a bus word or as fields
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [XLEN-APX_LEN-4:0] error_control;       // Reserved, read back only
        logic [APX_LEN-1:0]      bit_mask;            // 1 keeps that adder bit exact
        logic [1:0]              circuit_select;      // Only 0 is built
        logic                    approximate;         // Enable approximation
    } apx_fields_t;

    typedef union packed {
        logic [XLEN-1:0] raw;                         // AXI view
        apx_fields_t     fields;                      // ALU view
    } apx_csr_t;

    typedef struct packed {
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [6:0]      funct7;                      // Also imm[11:5] on OP_IMM
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] imm;                         // Already sign extended
    } exec_req_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            illegal;                     // Unsupported encoding
    } exec_resp_t;

endpackage

`default_nettype wire

// ==== design/approx_adder.sv ====
// Ripple adder whose low APX_LEN bits can drop the carry chain
// A cleared mask bit makes that bit approximate; upper bits are always exact
`timescale 1ns/1ns
`default_nettype none

module approx_adder (
    input  wire logic [exec_pkg::XLEN-1:0]    a,
    input  wire logic [exec_pkg::XLEN-1:0]    b,
    input  wire logic                         cin,
    input  wire logic [exec_pkg::APX_LEN-1:0] exact_mask,   // 1 = full adder at that bit
    output logic      [exec_pkg::XLEN-1:0]    sum
);

    logic [exec_pkg::XLEN-1:0] mask_full;                  // Mask widened to the word

    // Bits above the approximate window stay exact
    assign mask_full = {{(exec_pkg::XLEN - exec_pkg::APX_LEN){1'b1}}, exact_mask};

    // ----------------------------------------------------------------------
    // Carry chain
    // ----------------------------------------------------------------------
    always_comb begin
        logic c;                                           // Running carry
        c   = cin;
        sum = '0;
        for (int i = 0; i < exec_pkg::XLEN; i++) begin
            if (mask_full[i]) begin
                sum[i] = a[i] ^ b[i] ^ c;                  // Full adder
                c      = (a[i] & b[i]) | (c & (a[i] ^ b[i]));
            end else begin
                // Approximate cell ignores the incoming carry
                sum[i] = a[i] | b[i];
                c      = a[i] & b[i];                      // Generate only
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/alu_core.sv ====
// Combinational RV32I ALU for OP, OP_IMM, JAL, JALR and AUIPC
// Only ADD, ADDI and SUB see the approximate adder; link and AUIPC adds are exact
`timescale 1ns/1ns
`default_nettype none

module alu_core (
    input  wire exec_pkg::exec_req_t req,
    input  wire exec_pkg::apx_csr_t  apx_cfg,
    output exec_pkg::exec_resp_t     resp
);

    logic [exec_pkg::XLEN-1:0]    op1;                  // rs1 or pc
    logic [exec_pkg::XLEN-1:0]    op2;                  // rs2, imm or 4
    logic [4:0]                   shamt;
    logic                         is_sub;
    logic                         is_alt;               // funct7 selects SUB/SRA form
    logic                         is_alu_op;
    logic                         legal;
    logic [exec_pkg::APX_LEN-1:0] exact_mask;
    logic [exec_pkg::XLEN-1:0]    add_sum;              // Approximate adder result
    logic [exec_pkg::XLEN-1:0]    link_sum;             // Exact pc add
    logic [exec_pkg::XLEN-1:0]    alu_res;

    // ----------------------------------------------------------------------
    // Operand selection
    // ----------------------------------------------------------------------
    always_comb begin
        case (req.opcode)
            exec_pkg::OP: begin
                op1 = req.rs1;
                op2 = req.rs2;
            end
            exec_pkg::OP_IMM: begin
                op1 = req.rs1;
                op2 = req.imm;
            end
            exec_pkg::AUIPC: begin
                op1 = req.pc;
                op2 = req.imm;
            end
            default: begin                              // JAL, JALR link address
                op1 = req.pc;
                op2 = exec_pkg::XLEN'(4);
            end
        endcase
    end

    assign shamt     = op2[4:0];                        // rs2[4:0] or imm[4:0]
    assign is_alt    = (req.funct7 == exec_pkg::F7_ALT);
    assign is_sub    = (req.opcode == exec_pkg::OP) && (req.funct3 == exec_pkg::F3_ADD) && is_alt;
    assign is_alu_op = (req.opcode == exec_pkg::OP) || (req.opcode == exec_pkg::OP_IMM);

    // Mask only applies to the one built circuit
    assign exact_mask = (apx_cfg.fields.approximate && apx_cfg.fields.circuit_select == 2'b00)
                      ? apx_cfg.fields.bit_mask : '1;

    approx_adder i_approx_adder (
        .a          (op1),
        .b          (is_sub ? ~op2 : op2),              // Two's complement subtract
        .cin        (is_sub),
        .exact_mask (exact_mask),
        .sum        (add_sum)
    );

    assign link_sum = op1 + op2;                        // JAL, JALR, AUIPC

    // ----------------------------------------------------------------------
    // Operation select by funct3
    // ----------------------------------------------------------------------
    always_comb begin
        case (req.funct3)
            exec_pkg::F3_ADD:  alu_res = add_sum;
            exec_pkg::F3_SLL:  alu_res = op1 << shamt;
            exec_pkg::F3_SLT:  alu_res = {{(exec_pkg::XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            exec_pkg::F3_SLTU: alu_res = {{(exec_pkg::XLEN-1){1'b0}}, op1 < op2};
            exec_pkg::F3_XOR:  alu_res = op1 ^ op2;
            exec_pkg::F3_SR:   alu_res = is_alt ? $unsigned($signed(op1) >>> shamt) : op1 >> shamt;
            exec_pkg::F3_OR:   alu_res = op1 | op2;
            default:           alu_res = op1 & op2;     // AND
        endcase
    end

    // Legality of the full encoding
    always_comb begin
        case (req.opcode)
            exec_pkg::OP:     legal = (req.funct7 == exec_pkg::F7_BASE) || (is_alt &&
                                      (req.funct3 == exec_pkg::F3_ADD || req.funct3 == exec_pkg::F3_SR));
            exec_pkg::OP_IMM: begin
                case (req.funct3)
                    exec_pkg::F3_SLL: legal = (req.funct7 == exec_pkg::F7_BASE);
                    exec_pkg::F3_SR:  legal = (req.funct7 == exec_pkg::F7_BASE) || is_alt;
                    default:          legal = 1'b1;     // funct7 is just imm bits
                endcase
            end
            exec_pkg::JAL,
            exec_pkg::AUIPC:  legal = 1'b1;
            exec_pkg::JALR:   legal = (req.funct3 == 3'b000);
            default:          legal = 1'b0;             // Not handled here
        endcase
    end

    assign resp.result  = !legal ? '0 : (is_alu_op ? alu_res : link_sum);
    assign resp.illegal = !legal;

endmodule

`default_nettype wire

// ==== design/approx_csr.sv ====
// AXI4-Lite slave for the single approximation control word at address 0
// One outstanding write and one outstanding read; no burst or ID support
`timescale 1ns/1ns
`default_nettype none

module approx_csr (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    // Write address and data
    input  wire logic                               awvalid,
    output logic                                    awready,
    input  wire logic [exec_pkg::AXI_ADDR_W-1:0]    awaddr,
    input  wire logic                               wvalid,
    output logic                                    wready,
    input  wire logic [exec_pkg::XLEN-1:0]          wdata,
    input  wire logic [exec_pkg::XLEN/8-1:0]        wstrb,
    // Write response
    output logic                                    bvalid,
    input  wire logic                               bready,
    output logic [1:0]                              bresp,
    // Read
    input  wire logic                               arvalid,
    output logic                                    arready,
    input  wire logic [exec_pkg::AXI_ADDR_W-1:0]    araddr,
    output logic                                    rvalid,
    input  wire logic                               rready,
    output logic [exec_pkg::XLEN-1:0]               rdata,
    output logic [1:0]                              rresp,
    output exec_pkg::apx_csr_t                      apx_cfg
);

    logic wr_rdy;                                   // Shared AW/W ready pulse
    logic wr_fire;
    logic wr_hit;
    logic rd_fire;

    assign awready = wr_rdy;
    assign wready  = wr_rdy;
    assign wr_fire = wr_rdy && awvalid && wvalid;
    assign wr_hit  = (awaddr == exec_pkg::CSR_ADDR_APX);
    assign arready = !rvalid;                       // Free whenever no read pending
    assign rd_fire = arvalid && arready;

    // ----------------------------------------------------------------------
    // Control state and register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_rdy  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            apx_cfg <= '0;                          // Exact mode
        end else begin
            // One-cycle ready once both channels present, never with B pending
            wr_rdy <= awvalid && wvalid && !wr_rdy && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
                for (int i = 0; i < exec_pkg::XLEN / 8; i++) begin
                    if (wr_hit && wstrb[i])
                        apx_cfg.raw[8*i +: 8] <= wdata[8*i +: 8];   // Byte lane
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (wr_fire)
            bresp <= wr_hit ? exec_pkg::AXI_RESP_OKAY : exec_pkg::AXI_RESP_SLVERR;
        if (rd_fire) begin
            rdata <= (araddr == exec_pkg::CSR_ADDR_APX) ? apx_cfg.raw : '0;
            rresp <= (araddr == exec_pkg::CSR_ADDR_APX) ? exec_pkg::AXI_RESP_OKAY
                                                        : exec_pkg::AXI_RESP_SLVERR;
        end
    end

    // Responses must wait for the master
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid);
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire

// ==== design/exec_stage.sv ====
// One-deep registered execute stage, one cycle from accept to response
// CSR value is taken at the accepting edge; later CSR writes do not affect it
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 req_valid,
    output logic                      req_ready,
    input  wire exec_pkg::exec_req_t  req,
    output logic                      resp_valid,
    input  wire logic                 resp_ready,
    output exec_pkg::exec_resp_t      resp,
    input  wire exec_pkg::apx_csr_t   apx_cfg
);

    exec_pkg::exec_resp_t alu_resp;              // Combinational result
    logic                 req_fire;

    // ----------------------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------------------
    assign req_ready = !resp_valid || resp_ready;   // Slot frees as response leaves
    assign req_fire  = req_valid && req_ready;

    alu_core i_alu_core (
        .req     (req),
        .apx_cfg (apx_cfg),
        .resp    (alu_resp)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            resp_valid <= 1'b0;
        else if (req_ready)
            resp_valid <= req_valid;             // Refill or drain
    end

    // Result register, loads only on accept
    always_ff @(posedge clk) begin
        if (req_fire)
            resp <= alu_resp;
    end

    // Stalled response must not move
    a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

`default_nettype wire

// ==== design/exec_top.sv ====
// Execute stage with its approximation CSR on an AXI4-Lite port
// The two blocks share only the CSR value
`timescale 1ns/1ns
`default_nettype none

module exec_top (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    // Instruction path
    input  wire logic                               req_valid,
    output logic                                    req_ready,
    input  wire exec_pkg::exec_req_t                req,
    output logic                                    resp_valid,
    input  wire logic                               resp_ready,
    output exec_pkg::exec_resp_t                    resp,
    // AXI4-Lite CSR port
    input  wire logic                               awvalid,
    output logic                                    awready,
    input  wire logic [exec_pkg::AXI_ADDR_W-1:0]    awaddr,
    input  wire logic                               wvalid,
    output logic                                    wready,
    input  wire logic [exec_pkg::XLEN-1:0]          wdata,
    input  wire logic [exec_pkg::XLEN/8-1:0]        wstrb,
    output logic                                    bvalid,
    input  wire logic                               bready,
    output logic [1:0]                              bresp,
    input  wire logic                               arvalid,
    output logic                                    arready,
    input  wire logic [exec_pkg::AXI_ADDR_W-1:0]    araddr,
    output logic                                    rvalid,
    input  wire logic                               rready,
    output logic [exec_pkg::XLEN-1:0]               rdata,
    output logic [1:0]                              rresp
);

    exec_pkg::apx_csr_t apx_cfg;                 // CSR to ALU

    approx_csr i_approx_csr (.*);                // Port names match the top
    exec_stage i_exec_stage (.*);

endmodule

`default_nettype wire

// ==== test/tb_exec_top.sv ====
// Directed tests for exec_top; expected responses come from a behavioral RV32I model
// Responses are matched in order from a queue; the CSR shadow tracks every write
`timescale 1ns/1ns
`default_nettype none

module tb_exec_top;

    localparam int TIMEOUT = 2000;                  // About 4x the summed test length

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       req_valid, req_ready, resp_valid, resp_ready;
    exec_pkg::exec_req_t        req;
    exec_pkg::exec_resp_t       resp;
    logic                       awvalid, awready, wvalid, wready, bvalid, bready;
    logic                       arvalid, arready, rvalid, rready;
    logic [3:0]                 awaddr, araddr, wstrb;
    logic [31:0]                wdata, rdata;
    logic [1:0]                 bresp, rresp;
    exec_pkg::apx_csr_t         cfg;                // Shadow of the CSR
    exec_pkg::exec_resp_t       exp_q[$];           // Responses still owed, in order
    exec_pkg::exec_resp_t       held_resp;
    logic                       held_valid = 1'b0;
    logic                       stall_en = 1'b0;
    logic                       ready_next;         // Next resp_ready value
    integer                     seed = 32'h116f;
    int                         errors = 0;
    int                         cycles = 0;

    exec_top i_exec_top (.*);

    always #10 clk = ~clk;                          // 20 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    // Random back-pressure while stall_en is set, drawn on the edge
    always @(posedge clk) begin
        ready_next = stall_en ? $random(seed) : 1'b1;
        #2;
        resp_ready = ready_next;
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] model_add(input logic [31:0] a, input logic [31:0] b,
                                              input logic cin, input logic [7:0] mask);
        logic [31:0] s;
        logic        c;
        c = cin;
        for (int i = 0; i < 32; i++) begin
            if (i < exec_pkg::APX_LEN && !mask[i]) begin
                s[i] = a[i] | b[i];                 // Carry in dropped
                c    = a[i] & b[i];
            end else begin
                {c, s[i]} = a[i] + b[i] + c;
            end
        end
        return s;
    endfunction

    function automatic exec_pkg::exec_resp_t expected_resp(input exec_pkg::exec_req_t r,
                                                           input exec_pkg::apx_csr_t c);
        exec_pkg::exec_resp_t e;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [7:0]           mask;
        logic                 alt;
        logic                 sub;
        e    = '0;
        a    = r.rs1;
        b    = (r.opcode == exec_pkg::OP) ? r.rs2 : r.imm;
        alt  = (r.funct7 == 7'b0100000);
        sub  = (r.opcode == exec_pkg::OP) && alt;
        mask = (c.fields.approximate && c.fields.circuit_select == 2'd0)
             ? c.fields.bit_mask : 8'hff;
        if (r.opcode == exec_pkg::JAL || (r.opcode == exec_pkg::JALR && r.funct3 == 3'd0)) begin
            e.result = r.pc + 32'd4;                // Link address, always exact
        end else if (r.opcode == exec_pkg::AUIPC) begin
            e.result = r.pc + r.imm;
        end else if (r.opcode == exec_pkg::OP || r.opcode == exec_pkg::OP_IMM) begin
            case (r.funct3)
                3'd0:    e.result = model_add(a, sub ? ~b : b, sub, mask);
                3'd1:    e.result = a << b[4:0];
                3'd2:    e.result = 32'($signed(a) < $signed(b));
                3'd3:    e.result = 32'(a < b);
                3'd4:    e.result = a ^ b;
                3'd5:    e.result = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6:    e.result = a | b;
                default: e.result = a & b;
            endcase
            if (r.opcode == exec_pkg::OP)
                e.illegal = !(r.funct7 == 7'd0 || (alt && (r.funct3 == 3'd0 || r.funct3 == 3'd5)));
            else if (r.funct3 == 3'd1)
                e.illegal = (r.funct7 != 7'd0);     // SLLI
            else if (r.funct3 == 3'd5)
                e.illegal = !(r.funct7 == 7'd0 || alt);
        end else begin
            e.illegal = 1'b1;                       // Opcode outside the subset
        end
        if (e.illegal)
            e.result = '0;
        return e;
    endfunction

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_resp(input exec_pkg::exec_resp_t got, input exec_pkg::exec_resp_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: resp got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_code(input logic [1:0] code, input logic [1:0] code_exp,
                              input string code_name);
        if (code !== code_exp) begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, code_name, code, code_exp);
        end
    endtask

    task automatic check_csr(input exec_pkg::apx_csr_t got, input exec_pkg::apx_csr_t exp,
                             input logic [1:0] code, input logic [1:0] code_exp,
                             input string code_name);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: rdata got %h expected %h", $time, got.raw, exp.raw);
        end
        check_code(code, code_exp, code_name);
    endtask

    // In-order response monitor with a stall stability check
    always @(posedge clk) begin
        if (rst_n) begin
            if (held_valid && !resp_valid) begin
                errors++;
                $display("resp_valid dropped at %0t while the response was stalled", $time);
            end else if (held_valid) begin
                check_resp(resp, held_resp);
            end
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Response at %0t arrived with no request outstanding", $time);
                end else begin
                    check_resp(resp, exp_q.pop_front());
                end
            end
            held_valid = resp_valid && !resp_ready;
            held_resp  = resp;
        end
    end

    // ----------------------------------------------------------------------
    // Bus tasks
    // ----------------------------------------------------------------------
    task automatic send(input exec_pkg::exec_req_t r);
        exp_q.push_back(expected_resp(r, cfg));     // CSR as seen at acceptance
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready)
            @(posedge clk);
        #2 req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            @(posedge clk);
        #2;
    endtask

    function automatic exec_pkg::exec_req_t make_req(input logic [6:0] op, input logic [2:0] f3,
            input logic [6:0] f7, input logic [31:0] rs1, input logic [31:0] rs2,
            input logic [31:0] imm);
        exec_pkg::exec_req_t r;
        r = '{opcode: op, funct3: f3, funct7: f7, pc: 32'h0000_1000, rs1: rs1, rs2: rs2, imm: imm};
        return r;
    endfunction

    task automatic csr_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] code);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        #2 arvalid = 1'b0;
        @(posedge clk);
        while (!rvalid)
            @(posedge clk);
        data = rdata;                               // rready held high
        code = rresp;
        #2;
    endtask

    // Write, then read address 0 back against the shadow
    task automatic csr_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [1:0]  b_code;
        logic [1:0]  b_exp;
        logic [1:0]  r_code;
        logic [31:0] rd;
        b_exp = (addr == exec_pkg::CSR_ADDR_APX) ? exec_pkg::AXI_RESP_OKAY
                                                 : exec_pkg::AXI_RESP_SLVERR;
        for (int i = 0; i < 4; i++) begin
            if (addr == exec_pkg::CSR_ADDR_APX && strb[i])
                cfg.raw[8*i +: 8] = data[8*i +: 8]; // Byte lane
        end
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge clk);
        while (!awready)
            @(posedge clk);
        if (!wready) begin
            errors++;
            $display("wready was low at %0t while awready was high", $time);
        end
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(posedge clk);
        while (!bvalid)
            @(posedge clk);
        b_code = bresp;
        #2;
        check_code(b_code, b_exp, "bresp");
        csr_read(exec_pkg::CSR_ADDR_APX, rd, r_code);
        check_csr(rd, cfg, r_code, exec_pkg::AXI_RESP_OKAY, "rresp");
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_exact_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [6:0]  f7;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (!alt || f3 == 0 || f3 == 5) begin
                    for (int n = 0; n < 6; n++) begin
                        case (n)
                            0:       {a, b} = {32'h8000_0000, 32'd31};   // Shift of 31
                            1:       {a, b} = {32'hffff_ffff, 32'h7fff_ffff};
                            2:       {a, b} = {32'h7fff_ffff, 32'h8000_0000};
                            default: {a, b} = {$random(seed), $random(seed)};
                        endcase
                        f7 = alt ? 7'b0100000 : 7'b0000000;
                        send(make_req(exec_pkg::OP, f3, f7, a, b, 32'h0));
                        if (f3 == 1 || f3 == 5)
                            imm = {20'h0, f7, b[4:0]};
                        else
                            imm = {{20{b[11]}}, b[11:0]};
                        if (!(alt && f3 == 0))      // No SUBI
                            send(make_req(exec_pkg::OP_IMM, f3, imm[11:5], a, 32'h0, imm));
                    end
                end
            end
        end
        drain();
    endtask

    task automatic test_link_auipc();
        exec_pkg::exec_req_t r;
        csr_write(exec_pkg::CSR_ADDR_APX, 32'h0000_0001, 4'hf);   // All low bits approximate
        for (int n = 0; n < 4; n++) begin
            r    = make_req(exec_pkg::JAL, 3'd0, 7'd0, 32'h0, 32'h0, 32'h0);
            r.pc = (n == 0) ? 32'h0000_00fc : {$random(seed)} & 32'hffff_fffc;
            send(r);
            r.opcode = exec_pkg::JALR;
            send(r);
            r.opcode = exec_pkg::AUIPC;
            r.imm    = $random(seed);               // Low bits carry through the add
            send(r);
        end
        drain();
        csr_write(exec_pkg::CSR_ADDR_APX, 32'h0, 4'hf);
    endtask

    task automatic test_csr_access();
        logic [31:0] rd;
        logic [1:0]  code;
        csr_write(4'h0, 32'ha5a5_5a5a, 4'hf);
        csr_write(4'h0, 32'h1234_5678, 4'b0101);   // Partial strobe
        csr_write(4'h4, 32'hdead_beef, 4'hf);      // Unmapped, register unchanged
        csr_read(4'h4, rd, code);
        check_csr(rd, '0, code, exec_pkg::AXI_RESP_SLVERR, "rresp");
        csr_write(4'h0, 32'h0, 4'hf);
    endtask

    task automatic test_approx_add();
        logic [31:0] a;
        logic [31:0] b;
        for (int sel = 0; sel < 2; sel++) begin
            csr_write(exec_pkg::CSR_ADDR_APX, {21'h0, 8'ha5, 2'(sel), 1'b1}, 4'hf);
            for (int n = 0; n < 8; n++) begin
                a = (n == 0) ? 32'h0000_00ff : $random(seed);
                b = (n == 0) ? 32'h0000_0001 : $random(seed);
                send(make_req(exec_pkg::OP, 3'd0, 7'd0, a, b, 32'h0));
                send(make_req(exec_pkg::OP, 3'd0, 7'b0100000, a, b, 32'h0));
                send(make_req(exec_pkg::OP_IMM, 3'd0, b[11:5], a, 32'h0, {{20{b[11]}}, b[11:0]}));
            end
            drain();
        end
        csr_write(exec_pkg::CSR_ADDR_APX, 32'h0, 4'hf);
    endtask

    task automatic test_backpressure();
        logic [2:0] f3;
        logic [6:0] f7;
        stall_en = 1'b1;
        for (int n = 0; n < 40; n++) begin
            f3 = $random(seed);
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && $random(seed) % 2) ? 7'b0100000 : 7'd0;
            send(make_req(exec_pkg::OP, f3, f7, $random(seed), $random(seed), 32'h0));
        end
        drain();
        stall_en = 1'b0;
    endtask

    task automatic test_illegal();
        send(make_req(exec_pkg::OP, 3'd0, 7'b0000001, 32'd7, 32'd3, 32'h0));    // MUL
        send(make_req(exec_pkg::OP, 3'd4, 7'b0100000, 32'd7, 32'd3, 32'h0));
        send(make_req(exec_pkg::OP_IMM, 3'd1, 7'b0100000, 32'd7, 32'h0, 32'h401));
        send(make_req(7'b0000011, 3'd2, 7'd0, 32'd7, 32'd3, 32'd8));          // Load
        send(make_req(exec_pkg::JALR, 3'd1, 7'd0, 32'd7, 32'd3, 32'h0));
        drain();
    endtask

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        {awvalid, wvalid, arvalid} = 3'b000;
        {awaddr, araddr, wstrb}    = '0;
        wdata      = '0;
        bready     = 1'b1;
        rready     = 1'b1;
        cfg        = '0;                            // Reset value, exact mode
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
        test_exact_alu();
        test_link_auipc();
        test_csr_access();
        test_approx_add();
        test_backpressure();
        test_illegal();
        $display("Checks done, errors: %0d", errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/exec_pkg.sv
design/approx_adder.sv
design/alu_core.sv
design/approx_csr.sv
design/exec_stage.sv
design/exec_top.sv
test/tb_exec_top.sv
